// File: files.f
+incdir+verilog
verilog/preg_pkg.sv
verilog/rob_pkg.sv
verilog/rob_dispatch.sv
verilog/rob_entry.sv
verilog/rob_retire.sv
verilog/rob_top.sv
verification/rob_chk.sv
verification/rob_monitor.sv
verification/rob_tb.sv

// File: Makefile
# Verilator build and run for the reorder buffer

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= rob_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
RUN_FLAGS ?= +verilator+error+limit+100
LOG       ?= sim.log
PASS_TEXT := Simulation PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, judge the result from $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "test passed" || (echo "test failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/rob_tb.sv
////////////////////
// reorder buffer testbench
// clock, reset, stimulus table, drain and summary
////////////////////

`timescale 1ns/1ps

`include "rob_settings.svh"

module rob_tb;
	import preg_pkg::*;
	import rob_pkg::*;

	// one cycle of inputs in apply_row field order
	typedef struct packed {
		inst_num_t             num;
		pr_tag_t               tag0;
		pr_tag_t               told0;
		logic                  exec0;
		logic                  halt0;
		pr_tag_t               tag1;
		pr_tag_t               told1;
		logic                  exec1;
		logic                  halt1;
		logic [`CDB_WIDTH-1:0] cdb_valid;
		cdb_tags_t             cdb_tags;
	} stim_row_t;

	logic                  clock = 1'b0;
	logic                  reset;
	inst_num_t             dispatch_num;
	pr_tag_t               tag0;
	pr_tag_t               told0;
	logic                  exec0;
	logic                  halt0;
	pr_tag_t               tag1;
	pr_tag_t               told1;
	logic                  exec1;
	logic                  halt1;
	logic [`CDB_WIDTH-1:0] cdb_valid;
	cdb_tags_t             cdb_tags;
	inst_num_t             dispatch_cap;
	inst_num_t             retire_num;
	pr_tag_t               retire_told_a;
	pr_tag_t               retire_told_b;
	logic                  retire_halt;
	int                    error_count;
	int                    model_count;

	stim_row_t stim[$];
	int        stim_errors;
	logic      timed_out;

	rob_top rob_top_inst (.*);
	rob_monitor rob_monitor_inst (.*);

	always #2 clock = ~clock;   // 4 ns period

	function automatic pr_tag_t pick_tag();
		return pr_tag_t'($urandom);
	endfunction

	function automatic stim_row_t dispatch_row(inst_num_t num, logic ex0, pr_tag_t t0,
		logic ex1, pr_tag_t t1, logic h0, logic h1);
		stim_row_t r;
		r = '0;
		r.num = num;
		r.tag0 = t0;
		r.told0 = pick_tag();
		r.exec0 = ex0;
		r.halt0 = h0;
		r.tag1 = t1;
		r.told1 = pick_tag();
		r.exec1 = ex1;
		r.halt1 = h1;
		return r;
	endfunction

	function automatic stim_row_t broadcast_row(logic [`CDB_WIDTH-1:0] lanes, cdb_tags_t tags);
		stim_row_t r;
		r = '0;
		r.cdb_valid = lanes;
		r.cdb_tags = tags;
		return r;
	endfunction

	task automatic apply_row(stim_row_t r);
		{dispatch_num, tag0, told0, exec0, halt0, tag1, told1, exec1, halt1,
			cdb_valid, cdb_tags} = r;
	endtask

	////////////////////
	// stimulus table
	////////////////////
	task automatic build_table();
		pr_tag_t   base;
		cdb_tags_t lanes;
		repeat (2) stim.push_back(stim_row_t'(0));   // idle after reset
		repeat (4) stim.push_back(dispatch_row(2'd2, 1'b0, pick_tag(), 1'b0, pick_tag(),
			1'b0, 1'b0));
		repeat (4) stim.push_back(stim_row_t'(0));
		// younger completes first
		base = pick_tag();
		stim.push_back(dispatch_row(2'd2, 1'b1, base, 1'b1, pr_tag_t'(base + 1), 1'b0, 1'b0));
		stim.push_back(stim_row_t'(0));
		lanes = '0;
		lanes[0] = pr_tag_t'(base + 1);
		stim.push_back(broadcast_row(6'b000001, lanes));
		repeat (3) stim.push_back(stim_row_t'(0));
		lanes[2] = base;
		stim.push_back(broadcast_row(6'b000100, lanes));
		repeat (4) stim.push_back(stim_row_t'(0));
		// several lanes at once with one tag twice
		base = pick_tag();
		stim.push_back(dispatch_row(2'd2, 1'b1, base, 1'b1, pr_tag_t'(base + 1), 1'b0, 1'b0));
		stim.push_back(dispatch_row(2'd2, 1'b1, pr_tag_t'(base + 2), 1'b1, pr_tag_t'(base + 2),
			1'b0, 1'b0));
		stim.push_back(dispatch_row(2'd1, 1'b1, pr_tag_t'(base + 3), 1'b0, '0, 1'b0, 1'b0));
		stim.push_back(stim_row_t'(0));
		lanes = {pr_tag_t'(base + 3), pr_tag_t'(base + 3), pr_tag_t'(base + 2),
			pr_tag_t'(base + 2), pr_tag_t'(base + 1), base};
		stim.push_back(broadcast_row(6'b001111, lanes));   // lanes 4 and 5 off
		repeat (2) stim.push_back(stim_row_t'(0));
		stim.push_back(broadcast_row(6'b100000, lanes));
		repeat (4) stim.push_back(stim_row_t'(0));
		// fill all 64 so capacity steps 2 -> 1 -> 0
		base = pick_tag();
		repeat (31) stim.push_back(dispatch_row(2'd2, 1'b1, base, 1'b1, base, 1'b0, 1'b0));
		repeat (2) stim.push_back(dispatch_row(2'd1, 1'b1, base, 1'b1, base, 1'b0, 1'b0));
		stim.push_back(stim_row_t'(0));
		lanes = '0;
		lanes[1] = base;
		stim.push_back(broadcast_row(6'b000010, lanes));   // one wake for all
		repeat (34) stim.push_back(stim_row_t'(0));
		// stale tags in freed slots stay asleep
		stim.push_back(broadcast_row(6'b000010, lanes));
		repeat (2) stim.push_back(stim_row_t'(0));
		// streaming with halts over about three more passes
		for (int i = 0; i < 96; i++)
			stim.push_back(dispatch_row(2'd2, 1'b0, pick_tag(), 1'b0, pick_tag(),
				i % 11 == 3, i % 13 == 5));
	endtask

	initial
	begin
		int free_slots;
		int cap;
		int wait_cycles;
		int assert_errors;
		void'($urandom(57));
		reset = 1'b1;
		apply_row(stim_row_t'(0));
		stim_errors = 0;
		timed_out = 1'b0;
		build_table();
		repeat (10) @(posedge clock);
		#1 reset = 1'b0;
		foreach (stim[i])
		begin
			free_slots = `ROB_DEPTH - model_count;   // model already holds this edge
			cap = (free_slots > 1) ? 2 : free_slots;
			if (int'(stim[i].num) > cap)
			begin
				$display("stimulus row %0d asks for %0d slots with room for %0d",
					i, stim[i].num, cap);
				stim_errors++;
			end
			apply_row(stim[i]);
			@(posedge clock);
			#1;
		end
		apply_row(stim_row_t'(0));
		wait_cycles = 0;
		while (model_count != 0 && wait_cycles < 200)
		begin
			@(posedge clock);
			wait_cycles++;
		end
		if (model_count != 0)
		begin
			$display("timeout: buffer still holds %0d instructions after %0d cycles",
				model_count, wait_cycles);
			timed_out = 1'b1;
		end
		@(negedge clock);   // compare the empty state once more
		@(negedge clock);
		assert_errors = rob_top_inst.rob_chk_inst.fail_count;
		$display("errors: compare %0d, stimulus %0d, assertion %0d, timeout %0d",
			error_count, stim_errors, assert_errors, timed_out);
		if (error_count + stim_errors + assert_errors == 0 && !timed_out)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: verification/rob_monitor.sv
////////////////////
// reference model and output compare
// queue of in-flight instructions in program order
////////////////////

`timescale 1ns/1ps

`include "rob_settings.svh"

module rob_monitor (
	input  logic                  clock,
	input  logic                  reset,
	input  rob_pkg::inst_num_t    dispatch_num,
	input  preg_pkg::pr_tag_t     tag0,
	input  preg_pkg::pr_tag_t     told0,
	input  logic                  exec0,
	input  logic                  halt0,
	input  preg_pkg::pr_tag_t     tag1,
	input  preg_pkg::pr_tag_t     told1,
	input  logic                  exec1,
	input  logic                  halt1,
	input  logic [`CDB_WIDTH-1:0] cdb_valid,
	input  preg_pkg::cdb_tags_t   cdb_tags,
	input  rob_pkg::inst_num_t    dispatch_cap,
	input  rob_pkg::inst_num_t    retire_num,
	input  preg_pkg::pr_tag_t     retire_told_a,
	input  preg_pkg::pr_tag_t     retire_told_b,
	input  logic                  retire_halt,
	output int                    error_count,
	output int                    model_count
);
	import preg_pkg::*;

	pr_tag_t q_tag[$];
	pr_tag_t q_told[$];
	logic    q_halt[$];
	logic    q_ready[$];

	task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp)
		begin
			$display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic push_entry(pr_tag_t tag, pr_tag_t told, logic halt, logic exec);
		q_tag.push_back(tag);
		q_told.push_back(told);
		q_halt.push_back(halt);
		q_ready.push_back(!exec);   // nothing to execute, done on dispatch
	endtask

	////////////////////
	// compare mid cycle, then apply this cycle's events
	////////////////////
	always @(negedge clock)
	begin
		int      n;
		int      free_slots;
		pr_tag_t told_a;
		pr_tag_t told_b;
		logic    halt_any;
		if (reset)
		begin
			q_tag.delete();
			q_told.delete();
			q_halt.delete();
			q_ready.delete();
		end
		else
		begin
			free_slots = `ROB_DEPTH - q_tag.size();
			n = 0;
			if (q_ready.size() > 0 && q_ready[0])
				n = (q_ready.size() > 1 && q_ready[1]) ? 2 : 1;   // in order only
			told_a = (n > 0) ? q_told[0] : '1;
			told_b = (n > 1) ? q_told[1] : '1;
			halt_any = (n > 0 && q_halt[0]) || (n > 1 && q_halt[1]);
			compare("dispatch_cap", 32'(dispatch_cap), (free_slots > 1) ? 2 : free_slots);
			compare("retire_num", 32'(retire_num), n);
			compare("retire_told_a", 32'(retire_told_a), 32'(told_a));
			compare("retire_told_b", 32'(retire_told_b), 32'(told_b));
			compare("retire_halt", 32'(retire_halt), 32'(halt_any));
			// wake-up only sees entries already in place
			foreach (q_tag[i])
				for (int k = 0; k < `CDB_WIDTH; k++)
					if (cdb_valid[k] && cdb_tags[k] == q_tag[i])
						q_ready[i] = 1'b1;
			repeat (n)
			begin
				void'(q_tag.pop_front());
				void'(q_told.pop_front());
				void'(q_halt.pop_front());
				void'(q_ready.pop_front());
			end
			if (dispatch_num != 2'd0)
				push_entry(tag0, told0, halt0, exec0);
			if (dispatch_num == 2'd2)
				push_entry(tag1, told1, halt1, exec1);
		end
		model_count = q_tag.size();
	end

endmodule

// File: verification/rob_chk.sv
////////////////////
// bound assertions for the reorder buffer
// capacity, retire order and reset state
////////////////////

`timescale 1ns/1ps

module rob_chk (
	input logic               clock,
	input logic               reset,
	input rob_pkg::inst_num_t dispatch_num,
	input rob_pkg::inst_num_t dispatch_cap,
	input rob_pkg::inst_num_t retire_num,
	input logic               head_ready,
	input logic               head_valid,
	input logic               next_valid
);
	import rob_pkg::*;

	int fail_count;   // read by the testbench summary

	// dispatch stays within the advertised room
	cap_respected: assert property (@(posedge clock) disable iff (reset)
		dispatch_num <= dispatch_cap)
	else
	begin
		$error("dispatch_num above dispatch_cap");
		fail_count++;
	end

	// only live entries leave the buffer
	retire_live: assert property (@(posedge clock) disable iff (reset)
		retire_num != inst_num_t'(0) |-> head_valid)
	else
	begin
		$error("retired from an empty head entry");
		fail_count++;
	end

	two_need_head: assert property (@(posedge clock) disable iff (reset)
		retire_num == inst_num_t'(2) |-> head_ready && head_valid && next_valid)
	else
	begin
		$error("two retired without a ready head and two live entries");
		fail_count++;
	end

	// empty buffer right after any reset edge
	cap_after_reset: assert property (@(posedge clock)
		reset |=> dispatch_cap == inst_num_t'(2))
	else
	begin
		$error("dispatch_cap not 2 after reset");
		fail_count++;
	end

endmodule

bind rob_top rob_chk rob_chk_inst (
	.clock        (clock),
	.reset        (reset),
	.dispatch_num (dispatch_num),
	.dispatch_cap (dispatch_cap),
	.retire_num   (retire_num),
	.head_ready   (entry_ready[rob_retire_inst.head]),
	.head_valid   (entry_valid[rob_retire_inst.head]),
	.next_valid   (entry_valid[rob_retire_inst.head_plus_one])
);

// File: verilog/rob_top.sv
////////////////////
// reorder buffer top level
// dispatch allocator, entry array, retire unit
////////////////////

`timescale 1ns/1ps

`include "rob_settings.svh"

module rob_top (
	input  logic                  clock,
	input  logic                  reset,
	input  rob_pkg::inst_num_t    dispatch_num,
	input  preg_pkg::pr_tag_t     tag0,
	input  preg_pkg::pr_tag_t     told0,
	input  logic                  exec0,
	input  logic                  halt0,
	input  preg_pkg::pr_tag_t     tag1,
	input  preg_pkg::pr_tag_t     told1,
	input  logic                  exec1,
	input  logic                  halt1,
	input  logic [`CDB_WIDTH-1:0] cdb_valid,
	input  preg_pkg::cdb_tags_t   cdb_tags,
	output rob_pkg::inst_num_t    dispatch_cap,
	output rob_pkg::inst_num_t    retire_num,
	output preg_pkg::pr_tag_t     retire_told_a,
	output preg_pkg::pr_tag_t     retire_told_b,
	output logic                  retire_halt
);
	import preg_pkg::*;

	logic [`ROB_DEPTH-1:0]    entry_write;
	logic [`ROB_DEPTH-1:0]    entry_slot;
	logic [`ROB_DEPTH-1:0]    entry_clear;
	logic [`ROB_DEPTH-1:0]    entry_valid;
	logic [`ROB_DEPTH-1:0]    entry_ready;
	logic [`ROB_DEPTH-1:0]    entry_halt;
	pr_tag_t [`ROB_DEPTH-1:0] entry_told;

	rob_dispatch rob_dispatch_inst (
		.clock        (clock),
		.reset        (reset),
		.dispatch_num (dispatch_num),
		.retire_num   (retire_num),     // feeds the occupancy count
		.dispatch_cap (dispatch_cap),
		.entry_write  (entry_write),
		.entry_slot   (entry_slot)
	);

	////////////////////
	// entry array
	////////////////////
	for (genvar i = 0; i < `ROB_DEPTH; i++)
	begin : entry_gen
		rob_entry rob_entry_inst (
			.clock     (clock),
			.reset     (reset),
			.write     (entry_write[i]),
			.slot      (entry_slot[i]),
			.clear     (entry_clear[i]),
			.tag0      (tag0),
			.told0     (told0),
			.tag1      (tag1),
			.told1     (told1),
			.exec0     (exec0),
			.exec1     (exec1),
			.halt0     (halt0),
			.halt1     (halt1),
			.cdb_valid (cdb_valid),
			.cdb_tags  (cdb_tags),
			.valid     (entry_valid[i]),
			.ready     (entry_ready[i]),
			.halt      (entry_halt[i]),
			.tag       (),
			.told      (entry_told[i])
		);
	end

	rob_retire rob_retire_inst (
		.clock         (clock),
		.reset         (reset),
		.entry_ready   (entry_ready),
		.entry_halt    (entry_halt),
		.entry_told    (entry_told),
		.entry_clear   (entry_clear),
		.retire_num    (retire_num),
		.retire_told_a (retire_told_a),
		.retire_told_b (retire_told_b),
		.retire_halt   (retire_halt)
	);

endmodule

// File: verilog/rob_retire.sv
////////////////////
// retire unit
// head pointer, in-order pick of up to
// two ready entries, free-list outputs
////////////////////

`timescale 1ns/1ps

`include "rob_settings.svh"

module rob_retire (
	input  logic                                  clock,
	input  logic                                  reset,
	input  logic [`ROB_DEPTH-1:0]                 entry_ready,
	input  logic [`ROB_DEPTH-1:0]                 entry_halt,
	input  preg_pkg::pr_tag_t [`ROB_DEPTH-1:0]    entry_told,
	output logic [`ROB_DEPTH-1:0]                 entry_clear,
	output rob_pkg::inst_num_t                    retire_num,
	output preg_pkg::pr_tag_t                     retire_told_a,
	output preg_pkg::pr_tag_t                     retire_told_b,
	output logic                                  retire_halt
);
	import rob_pkg::*;

	rob_idx_t head;
	rob_idx_t head_plus_one;
	logic     take_a;
	logic     take_b;

	assign head_plus_one = head + rob_idx_t'(1);

	// second slot only behind a ready head
	assign take_a = entry_ready[head];
	assign take_b = take_a && entry_ready[head_plus_one];

	assign retire_num = take_b ? inst_num_t'(2) : (take_a ? inst_num_t'(1) : inst_num_t'(0));

	////////////////////
	// free list handoff
	////////////////////
	assign retire_told_a = take_a ? entry_told[head] : '1;          // all ones when idle
	assign retire_told_b = take_b ? entry_told[head_plus_one] : '1;
	assign retire_halt = (take_a && entry_halt[head])
		|| (take_b && entry_halt[head_plus_one]);

	always_comb
	begin
		for (int i = 0; i < `ROB_DEPTH; i++)
		begin
			entry_clear[i] = (take_a && (rob_idx_t'(i) == head))
				|| (take_b && (rob_idx_t'(i) == head_plus_one));
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			head <= '0;
		else
			head <= head + rob_idx_t'(retire_num);   // wraps at depth
	end

endmodule

// File: verilog/rob_entry.sv
////////////////////
// single reorder buffer slot
// tags, halt, ready, valid and wake-up
////////////////////

`timescale 1ns/1ps

`include "rob_settings.svh"

module rob_entry (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   write,
	input  logic                   slot,
	input  logic                   clear,
	input  preg_pkg::pr_tag_t      tag0,
	input  preg_pkg::pr_tag_t      told0,
	input  preg_pkg::pr_tag_t      tag1,
	input  preg_pkg::pr_tag_t      told1,
	input  logic                   exec0,
	input  logic                   exec1,
	input  logic                   halt0,
	input  logic                   halt1,
	input  logic [`CDB_WIDTH-1:0]  cdb_valid,
	input  preg_pkg::cdb_tags_t    cdb_tags,
	output logic                   valid,
	output logic                   ready,
	output logic                   halt,
	output preg_pkg::pr_tag_t      tag,
	output preg_pkg::pr_tag_t      told
);

	logic cdb_hit;

	// any active lane carrying our tag, duplicates are harmless
	always_comb
	begin
		cdb_hit = 1'b0;
		for (int k = 0; k < `CDB_WIDTH; k++)
			cdb_hit = cdb_hit | (cdb_valid[k] && (cdb_tags[k] == tag));
	end

	// control state
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid <= 1'b0;
			ready <= 1'b0;
		end
		else if (write)   // wins over a clear on the same slot
		begin
			valid <= 1'b1;
			ready <= slot ? !exec1 : !exec0;   // no execution means done now
		end
		else if (clear)
		begin
			valid <= 1'b0;
			ready <= 1'b0;
		end
		else if (valid && !ready && cdb_hit)
			ready <= 1'b1;
	end

	// payload
	always_ff @(posedge clock)
	begin
		if (write)
		begin
			tag  <= slot ? tag1 : tag0;
			told <= slot ? told1 : told0;
			halt <= slot ? halt1 : halt0;
		end
	end

endmodule

// File: verilog/rob_dispatch.sv
////////////////////
// dispatch allocator
// tail pointer, occupancy count, capacity
// and per-entry write selects
////////////////////

`timescale 1ns/1ps

`include "rob_settings.svh"

module rob_dispatch (
	input  logic                  clock,
	input  logic                  reset,
	input  rob_pkg::inst_num_t    dispatch_num,
	input  rob_pkg::inst_num_t    retire_num,
	output rob_pkg::inst_num_t    dispatch_cap,
	output logic [`ROB_DEPTH-1:0] entry_write,
	output logic [`ROB_DEPTH-1:0] entry_slot
);
	import rob_pkg::*;

	rob_idx_t tail;
	rob_idx_t tail_plus_one;
	rob_cnt_t occupancy;
	rob_cnt_t free_cnt;

	assign tail_plus_one = tail + rob_idx_t'(1);   // wraps at depth
	assign free_cnt = rob_cnt_t'(`ROB_DEPTH) - occupancy;

	// capacity straight from registered count
	always_comb
	begin
		if (free_cnt == rob_cnt_t'(0))
			dispatch_cap = inst_num_t'(0);
		else if (free_cnt == rob_cnt_t'(1))
			dispatch_cap = inst_num_t'(1);
		else
			dispatch_cap = inst_num_t'(2);
	end

	////////////////////
	// entry selects
	////////////////////
	always_comb
	begin
		for (int i = 0; i < `ROB_DEPTH; i++)
		begin
			entry_write[i] = ((dispatch_num != inst_num_t'(0)) && (rob_idx_t'(i) == tail))
				|| ((dispatch_num == inst_num_t'(2)) && (rob_idx_t'(i) == tail_plus_one));
			entry_slot[i] = (rob_idx_t'(i) == tail_plus_one);   // slot 1 lands behind tail
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			tail      <= '0;
			occupancy <= '0;
		end
		else
		begin
			tail      <= tail + rob_idx_t'(dispatch_num);
			occupancy <= occupancy + rob_cnt_t'(dispatch_num) - rob_cnt_t'(retire_num);
		end
	end

endmodule

// File: verilog/rob_pkg.sv
////////////////////
// reorder buffer types
// positions, occupancy and per-cycle counts
////////////////////

`include "rob_settings.svh"

package rob_pkg;

	// position in the buffer, wraps naturally
	typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

	// 0 .. ROB_DEPTH, one extra bit for full
	typedef logic [$clog2(`ROB_DEPTH):0] rob_cnt_t;

	// 0, 1 or 2 instructions in a cycle
	typedef logic [$clog2(`DISPATCH_WIDTH+1)-1:0] inst_num_t;

endpackage

// File: verilog/preg_pkg.sv
////////////////////
// physical register types
// tag and result broadcast bundle
////////////////////

`include "rob_settings.svh"

package preg_pkg;

	// one renamed register
	typedef logic [`PR_WIDTH-1:0] pr_tag_t;

	// one tag per broadcast lane, lane 0 in the low bits
	typedef logic [`CDB_WIDTH-1:0][`PR_WIDTH-1:0] cdb_tags_t;

endpackage

// File: verilog/rob_settings.svh
////////////////////
// reorder buffer sizing macros
// depth, tag width, broadcast lanes, dispatch width
////////////////////

`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// entries in the circular buffer, power of two only
`define ROB_DEPTH 64

`define PR_WIDTH 7       // physical register tag bits
`define CDB_WIDTH 6      // result broadcast lanes

// fixed by the two-slot port layout
`define DISPATCH_WIDTH 2

`endif
